// File: logic/chiplet_pkg.sv
package chiplet_pkg;

    localparam int NODE_W = 4;
    localparam int CHECKSUM_W = 32;
    localparam int MAX_PAYLOAD = 64;  // Largest payload in words

    typedef logic [NODE_W-1:0] node_id_t;
    typedef logic [CHECKSUM_W-1:0] checksum_t;

    typedef enum logic [1:0] {
        HEAD = 2'd0,
        BODY = 2'd1,
        TAIL = 2'd2
    } flit_kind_e;

    typedef struct packed {
        logic valid;
        flit_kind_e kind;
        logic [31:0] data;
    } flit_t;

    // Data word of a head flit, also word 0 of a stored message
    typedef struct packed {
        node_id_t dest;
        node_id_t src;
        logic [7:0] len;  // Payload words
        logic [6:0] meta;
        logic [8:0] rsvd;
    } pkt_header_t;

endpackage

// File: logic/endpoint_map_pkg.sv
package endpoint_map_pkg;

    localparam int CACHE_WORDS = 128;
    localparam int CACHE_AW = 7;
    localparam int NUM_MSGS = 4;
    localparam int MSG_IW = $clog2(NUM_MSGS);
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    localparam logic [15:0] START_BASE = 16'h0000;
    localparam logic [15:0] SEND_ADDR = 16'h1004;
    localparam logic [15:0] TX_BASE = 16'h2000;
    localparam logic [15:0] RX_BASE = 16'h3000;
    localparam logic [15:0] FIFO_POP_ADDR = 16'h3400;
    localparam logic [15:0] FIFO_STAT_ADDR = 16'h3404;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
        logic [3:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic pready;
        logic [31:0] prdata;
        logic pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic en;
        logic we;
        logic [CACHE_AW-1:0] addr;
        logic [31:0] wdata;
        logic [3:0] strb;
    } cache_req_t;

    typedef enum logic {
        ENGINE = 1'b0,
        BUS = 1'b1
    } cache_owner_e;

    typedef struct packed {
        chiplet_pkg::node_id_t src;
        logic [7:0] len;
        logic [CACHE_AW-1:0] start;
        logic [6:0] meta;
        logic crc_err;
    } rx_entry_t;

endpackage

// File: logic/word_cache.sv
module word_cache (
    input  logic clk,
    input  logic n_rst,
    input  endpoint_map_pkg::cache_req_t req,
    output logic [31:0] rdata
);
    import endpoint_map_pkg::*;

    logic [31:0] mem [CACHE_WORDS];

    always_ff @(posedge clk) begin
        if (req.en && req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strb[b]) begin
                    mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.en && !req.we) begin
            rdata <= mem[req.addr];  // Valid the cycle after en
        end
    end

    a_addr_known: assert property (@(posedge clk) disable iff (!n_rst)
        req.en |-> !$isunknown(req.addr))
        else $error("cache access with an unknown word address");

endmodule

// File: logic/tx_engine.sv
module tx_engine (
    input  logic clk,
    input  logic n_rst,
    input  logic send_pulse,
    input  logic [endpoint_map_pkg::MSG_IW-1:0] send_index,
    input  logic [endpoint_map_pkg::CACHE_AW-1:0] start_word,
    input  chiplet_pkg::node_id_t node_id,
    output endpoint_map_pkg::cache_req_t cache_req,
    input  logic cache_grant,
    input  logic [31:0] cache_rdata,
    output chiplet_pkg::flit_t tx_flit,
    input  logic tx_ready,
    output logic busy
);
    import chiplet_pkg::*;
    import endpoint_map_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_HDR,
        SEND_HDR,
        FETCH_WORD,
        SEND_WORD,
        SEND_TAIL
    } tx_state_e;

    tx_state_e state;
    logic [NUM_MSGS-1:0] pending;
    logic [NUM_MSGS-1:0][CACHE_AW-1:0] start_tbl;
    logic [MSG_IW-1:0] pick_idx;
    logic [CACHE_AW-1:0] rd_ptr;
    logic [CACHE_AW-1:0] rd_addr;
    logic [7:0] remain;
    checksum_t csum;
    pkt_header_t hdr;
    flit_t flit_q;
    logic advance;
    logic step;

    always_comb begin
        pick_idx = '0;
        for (int i = NUM_MSGS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick_idx = MSG_IW'(i);
            end
        end
    end

    // rd_ptr is the word now on cache_rdata, so a transfer moves the read one word ahead
    assign advance = flit_q.valid && tx_ready;
    assign step = advance || (state == FETCH_WORD);
    assign rd_addr = rd_ptr + CACHE_AW'(step);  // Wraps at the cache end

    always_comb begin
        hdr = pkt_header_t'(cache_rdata);
        hdr.src = node_id;
    end

    always_comb begin
        cache_req = '0;
        cache_req.en = state inside {FETCH_HDR, FETCH_WORD, SEND_HDR, SEND_WORD};
        cache_req.addr = rd_addr;
    end

    always_ff @(posedge clk) begin
        if (send_pulse) begin
            start_tbl[send_index] <= start_word;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= IDLE;
            pending <= '0;
            flit_q <= '0;
            rd_ptr <= '0;
            remain <= '0;
            csum <= '0;
        end else begin
            rd_ptr <= rd_addr;
            case (state)
                IDLE: begin
                    if (|pending) begin
                        pending[pick_idx] <= 1'b0;
                        rd_ptr <= start_tbl[pick_idx];
                        state <= FETCH_HDR;
                    end
                end
                FETCH_HDR: begin
                    if (cache_grant) begin
                        state <= FETCH_WORD;
                    end
                end
                FETCH_WORD: begin  // Header arrives while payload word 1 is read
                    flit_q.valid <= 1'b1;
                    flit_q.kind <= HEAD;
                    flit_q.data <= hdr;
                    csum <= hdr;
                    remain <= hdr.len;
                    state <= SEND_HDR;
                end
                SEND_HDR, SEND_WORD: begin
                    if (advance && remain != '0) begin
                        flit_q.kind <= BODY;
                        flit_q.data <= cache_rdata;
                        csum <= csum ^ cache_rdata;
                        remain <= remain - 8'd1;
                        state <= SEND_WORD;
                    end else if (advance) begin
                        flit_q.kind <= TAIL;
                        flit_q.data <= csum;
                        state <= SEND_TAIL;
                    end
                end
                SEND_TAIL: begin
                    if (advance) begin
                        flit_q.valid <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (send_pulse) begin
                pending[send_index] <= 1'b1;
            end
        end
    end

    assign tx_flit = flit_q;
    assign busy = (state != IDLE) || (|pending);

    a_flit_hold: assert property (@(posedge clk) disable iff (!n_rst)
        tx_flit.valid && !tx_ready |=> $stable(tx_flit))
        else $error("tx flit changed while stalled");

endmodule

// File: logic/rx_engine.sv
module rx_engine (
    input  logic clk,
    input  logic n_rst,
    input  chiplet_pkg::flit_t rx_flit,
    output logic rx_ready,
    output endpoint_map_pkg::cache_req_t cache_req,
    input  logic cache_grant,
    output logic push,
    output endpoint_map_pkg::rx_entry_t entry
);
    import chiplet_pkg::*;
    import endpoint_map_pkg::*;

    typedef enum logic [1:0] {
        WAIT_HEAD,
        PAYLOAD,
        CHECK
    } rx_state_e;

    rx_state_e state;
    pkt_header_t in_hdr;
    pkt_header_t hdr_q;
    checksum_t csum;
    logic [CACHE_AW-1:0] wr_ptr;
    logic [CACHE_AW-1:0] wr_addr;
    logic [CACHE_AW-1:0] start_q;
    logic [31:0] wr_data;
    logic wr_pend;
    logic crc_err_q;
    logic take;
    logic accept_head;
    logic accept_body;
    logic accept_tail;

    assign rx_ready = 1'b1;  // Body words go through a one-stage write register
    assign take = rx_flit.valid && rx_ready;
    assign in_hdr = rx_flit.data;
    assign accept_head = take && rx_flit.kind == HEAD && state != PAYLOAD;
    assign accept_body = take && rx_flit.kind == BODY && state == PAYLOAD;
    assign accept_tail = take && rx_flit.kind == TAIL && state == PAYLOAD;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= WAIT_HEAD;
            wr_ptr <= '0;
            wr_addr <= '0;
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= accept_body;
            if (accept_body) begin
                wr_addr <= wr_ptr;
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at the cache end
            end
            case (state)
                WAIT_HEAD, CHECK: state <= accept_head ? PAYLOAD : WAIT_HEAD;
                PAYLOAD: begin
                    if (accept_tail) begin
                        state <= CHECK;
                    end
                end
                default: state <= WAIT_HEAD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept_head) begin
            hdr_q <= in_hdr;
            csum <= rx_flit.data;
            start_q <= wr_ptr;
        end
        if (accept_body) begin
            wr_data <= rx_flit.data;
            csum <= csum ^ rx_flit.data;
        end
        if (accept_tail) begin
            crc_err_q <= csum != rx_flit.data;
        end
    end

    // Request is held through the packet so the cache stays with the engine
    always_comb begin
        cache_req.en = (state != WAIT_HEAD) || wr_pend;
        cache_req.we = wr_pend;
        cache_req.addr = wr_addr;
        cache_req.wdata = wr_data;
        cache_req.strb = '1;
    end

    assign push = state == CHECK;
    assign entry.src = hdr_q.src;
    assign entry.len = hdr_q.len;
    assign entry.start = start_q;
    assign entry.meta = hdr_q.meta;
    assign entry.crc_err = crc_err_q;

    a_no_body_idle: assert property (@(posedge clk) disable iff (!n_rst)
        state == WAIT_HEAD && take |-> rx_flit.kind != BODY)
        else $error("BODY flit outside a packet");

    a_head_len: assert property (@(posedge clk) disable iff (!n_rst)
        accept_head |-> in_hdr.len != '0 && int'(in_hdr.len) <= MAX_PAYLOAD)
        else $error("header length out of range");

    // Ownership is registered in the top level, so this checks its one-cycle lead
    a_write_granted: assert property (@(posedge clk) disable iff (!n_rst)
        wr_pend |-> cache_grant)
        else $error("rx cache write without ownership");

endmodule

// File: logic/req_fifo.sv
module req_fifo (
    input  logic clk,
    input  logic n_rst,
    input  logic push,
    input  endpoint_map_pkg::rx_entry_t entry_in,
    input  logic pop,
    output endpoint_map_pkg::rx_entry_t head,
    output logic [endpoint_map_pkg::FIFO_AW:0] count,
    output logic overflow
);
    import endpoint_map_pkg::*;

    rx_entry_t mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic do_push;
    logic do_pop;

    assign do_pop = pop && count != '0;
    assign do_push = push && (int'(count) != FIFO_DEPTH || do_pop);
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_in;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            if (push && !do_push) begin
                overflow <= 1'b1;  // Sticky until reset
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!n_rst)
        int'(count) <= FIFO_DEPTH)
        else $error("FIFO count above depth");

endmodule

// File: logic/endpoint.sv
module endpoint (
    input  logic clk,
    input  logic n_rst,
    input  endpoint_map_pkg::apb_req_t apb_req,
    output endpoint_map_pkg::apb_rsp_t apb_rsp,
    input  chiplet_pkg::node_id_t node_id,
    output chiplet_pkg::flit_t tx_flit,
    input  logic tx_ready,
    input  chiplet_pkg::flit_t rx_flit,
    output logic rx_ready
);
    import endpoint_map_pkg::*;

    logic [NUM_MSGS-1:0][CACHE_AW+1:0] start_addr;
    cache_owner_e tx_owner;
    cache_owner_e rx_owner;
    cache_req_t tx_eng_req;
    cache_req_t rx_eng_req;
    cache_req_t bus_req;
    cache_req_t tx_cache_req;
    cache_req_t rx_cache_req;
    logic [31:0] tx_rdata;
    logic [31:0] rx_rdata;
    logic access;
    logic bus_wait;
    logic tx_issue;
    logic rx_issue;
    logic hit_start;
    logic hit_send;
    logic hit_tx;
    logic hit_rx;
    logic hit_pop;
    logic hit_stat;
    logic [MSG_IW-1:0] reg_idx;
    logic [MSG_IW-1:0] send_index;
    logic send_pulse;
    logic tx_busy;
    logic fifo_push;
    logic fifo_pop;
    logic overflow;
    rx_entry_t rx_entry;
    rx_entry_t fifo_head;
    logic [FIFO_AW:0] fifo_count;

    assign access = apb_req.psel && apb_req.penable;
    assign hit_start = apb_req.paddr[15:MSG_IW+2] == START_BASE[15:MSG_IW+2];
    assign hit_send = apb_req.paddr == SEND_ADDR;
    assign hit_tx = apb_req.paddr[15:CACHE_AW+2] == TX_BASE[15:CACHE_AW+2];
    assign hit_rx = apb_req.paddr[15:CACHE_AW+2] == RX_BASE[15:CACHE_AW+2];
    assign hit_pop = apb_req.paddr == FIFO_POP_ADDR;
    assign hit_stat = apb_req.paddr == FIFO_STAT_ADDR;
    assign reg_idx = apb_req.paddr[2 +: MSG_IW];
    assign send_index = apb_req.pwdata[MSG_IW-1:0];

    // A bus cache access is issued once and answered on the next cycle
    assign tx_issue = access && hit_tx && tx_owner == BUS && !bus_wait;
    assign rx_issue = access && hit_rx && !apb_req.pwrite && rx_owner == BUS && !bus_wait;

    always_comb begin
        bus_req.en = 1'b0;
        bus_req.we = apb_req.pwrite;
        bus_req.addr = apb_req.paddr[CACHE_AW+1:2];
        bus_req.wdata = apb_req.pwdata;
        bus_req.strb = apb_req.pstrb;
        tx_cache_req = bus_req;
        tx_cache_req.en = tx_issue;
        rx_cache_req = bus_req;
        rx_cache_req.en = rx_issue;
        if (tx_owner == ENGINE) begin
            tx_cache_req = tx_eng_req;
        end
        if (rx_owner == ENGINE) begin
            rx_cache_req = rx_eng_req;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            start_addr <= '0;
            tx_owner <= BUS;
            rx_owner <= BUS;
            bus_wait <= 1'b0;
        end else begin
            tx_owner <= tx_eng_req.en ? ENGINE : BUS;
            rx_owner <= rx_eng_req.en ? ENGINE : BUS;
            bus_wait <= tx_issue || rx_issue;
            if (access && apb_req.pwrite && hit_start) begin
                start_addr[reg_idx] <= {apb_req.pwdata[CACHE_AW+1:2], 2'b00};
            end
        end
    end

    always_comb begin
        apb_rsp.pready = 1'b0;
        apb_rsp.prdata = '0;
        apb_rsp.pslverr = 1'b0;
        send_pulse = 1'b0;
        fifo_pop = 1'b0;
        if (access) begin
            if (hit_start) begin
                apb_rsp.pready = 1'b1;
                apb_rsp.prdata = 32'(start_addr[reg_idx]);
            end else if (hit_send) begin
                apb_rsp.pready = 1'b1;
                if (apb_req.pwrite && apb_req.pwdata < NUM_MSGS) begin
                    send_pulse = 1'b1;
                end else if (apb_req.pwrite) begin
                    apb_rsp.pslverr = 1'b1;
                end
            end else if (hit_tx) begin
                apb_rsp.pready = bus_wait;  // Held low while the engine owns the cache
                apb_rsp.prdata = tx_rdata;
            end else if (hit_rx && apb_req.pwrite) begin
                apb_rsp.pready = 1'b1;
                apb_rsp.pslverr = 1'b1;
            end else if (hit_rx) begin
                apb_rsp.pready = bus_wait;
                apb_rsp.prdata = rx_rdata;
            end else if (hit_pop || hit_stat) begin
                apb_rsp.pready = 1'b1;
                apb_rsp.pslverr = apb_req.pwrite;
                if (!apb_req.pwrite && hit_pop && fifo_count != '0) begin
                    apb_rsp.prdata = 32'(fifo_head);
                    fifo_pop = 1'b1;
                end else if (!apb_req.pwrite && hit_stat) begin
                    apb_rsp.prdata[FIFO_AW:0] = fifo_count;
                    apb_rsp.prdata[8] = overflow;
                    apb_rsp.prdata[9] = tx_busy;
                end
            end else begin
                apb_rsp.pready = 1'b1;
                apb_rsp.pslverr = 1'b1;
            end
        end
    end

    word_cache u_tx_cache (
        .clk(clk),
        .n_rst(n_rst),
        .req(tx_cache_req),
        .rdata(tx_rdata)
    );

    word_cache u_rx_cache (
        .clk(clk),
        .n_rst(n_rst),
        .req(rx_cache_req),
        .rdata(rx_rdata)
    );

    tx_engine u_tx_engine (
        .clk(clk),
        .n_rst(n_rst),
        .send_pulse(send_pulse),
        .send_index(send_index),
        .start_word(start_addr[send_index][CACHE_AW+1:2]),
        .node_id(node_id),
        .cache_req(tx_eng_req),
        .cache_grant(tx_owner == ENGINE),
        .cache_rdata(tx_rdata),
        .tx_flit(tx_flit),
        .tx_ready(tx_ready),
        .busy(tx_busy)
    );

    rx_engine u_rx_engine (
        .clk(clk),
        .n_rst(n_rst),
        .rx_flit(rx_flit),
        .rx_ready(rx_ready),
        .cache_req(rx_eng_req),
        .cache_grant(rx_owner == ENGINE),
        .push(fifo_push),
        .entry(rx_entry)
    );

    req_fifo u_req_fifo (
        .clk(clk),
        .n_rst(n_rst),
        .push(fifo_push),
        .entry_in(rx_entry),
        .pop(fifo_pop),
        .head(fifo_head),
        .count(fifo_count),
        .overflow(overflow)
    );

endmodule

// File: sim/endpoint_tb.sv
module endpoint_tb;
    import chiplet_pkg::*;
    import endpoint_map_pkg::*;

    localparam int SEED = 99821;
    localparam int WAIT_LIMIT = 2000;  // Clock cycles allowed for any single wait
    localparam node_id_t NODE_ID = 4'h6;

    logic clk;
    logic n_rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    node_id_t node_id;
    flit_t tx_flit;
    logic tx_ready;
    flit_t rx_flit;
    logic rx_ready;

    flit_t tx_q[$];
    logic [31:0] pkt_words[$];
    int test_errs;
    int tests_run;
    int tests_failed;
    logic aborted;

    endpoint DUT (
        .clk(clk),
        .n_rst(n_rst),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .node_id(node_id),
        .tx_flit(tx_flit),
        .tx_ready(tx_ready),
        .rx_flit(rx_flit),
        .rx_ready(rx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Switch sink that stalls about one cycle in four
    initial begin
        void'($urandom(SEED));
        tx_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (n_rst && tx_flit.valid && tx_ready) begin
                tx_q.push_back(tx_flit);
            end
            tx_ready <= ($urandom % 4) != 0;
        end
    end

    function automatic flit_t make_flit(input flit_kind_e kind, input logic [31:0] data);
        flit_t f;
        f.valid = 1'b1;
        f.kind = kind;
        f.data = data;
        return f;
    endfunction

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flit(input flit_t got, input flit_t exp);
        if (got !== exp) begin
            $display("error at %0t: tx flit %s %h, expected %s %h", $time,
                     got.kind.name(), got.data, exp.kind.name(), exp.data);
            test_errs++;
        end
    endtask

    task automatic check_entry(input rx_entry_t got, input rx_entry_t exp);
        if (got !== exp) begin
            $display("error at %0t: FIFO entry src %h len %0d start %0d meta %h err %b",
                     $time, got.src, got.len, got.start, got.meta, got.crc_err);
            $display("    expected src %h len %0d start %0d meta %h err %b",
                     exp.src, exp.len, exp.start, exp.meta, exp.crc_err);
            test_errs++;
        end
    endtask

    task automatic apb_access(input logic write, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err, output logic done);
        int n;
        @(posedge clk);
        apb_req.psel <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite <= write;
        apb_req.paddr <= addr;
        apb_req.pwdata <= wdata;
        apb_req.pstrb <= strb;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);  // Response settles mid-cycle and transfers on the next edge
            n++;
        end while (!apb_rsp.pready && n < WAIT_LIMIT);
        done = apb_rsp.pready;
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel <= 1'b0;
        apb_req.penable <= 1'b0;
        if (!done) begin
            $display("APB access to %h never completed", addr);
            aborted = 1'b1;
        end
    endtask

    task automatic send_flit(input flit_kind_e kind, input logic [31:0] data);
        int n;
        rx_flit <= make_flit(kind, data);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rx_ready && n < WAIT_LIMIT);
        if (!rx_ready) begin
            $display("the endpoint never accepted an rx flit");
            aborted = 1'b1;
        end
    endtask

    task automatic inject_packet(input logic [31:0] hdr, input logic good);
        checksum_t sum;
        sum = hdr;
        @(posedge clk);
        send_flit(HEAD, hdr);
        foreach (pkt_words[i]) begin
            send_flit(BODY, pkt_words[i]);
            sum = sum ^ pkt_words[i];
        end
        send_flit(TAIL, good ? sum : ~sum);
        rx_flit.valid <= 1'b0;
        repeat (2) @(posedge clk);  // Entry reaches the FIFO two cycles after the TAIL
    endtask

    task automatic expect_packet(input logic [31:0] stored_hdr);
        pkt_header_t hdr;
        checksum_t sum;
        flit_t got;
        int need;
        int n;
        hdr = pkt_header_t'(stored_hdr);
        hdr.src = NODE_ID;  // The endpoint stamps its own node number
        need = pkt_words.size() + 2;
        n = 0;
        while (tx_q.size() < need && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (tx_q.size() < need) begin
            $display("tx packet with header %h did not arrive", stored_hdr);
            aborted = 1'b1;
        end else begin
            sum = hdr;
            got = tx_q.pop_front();
            check_flit(got, make_flit(HEAD, hdr));
            foreach (pkt_words[i]) begin
                got = tx_q.pop_front();
                check_flit(got, make_flit(BODY, pkt_words[i]));
                sum = sum ^ pkt_words[i];
            end
            got = tx_q.pop_front();
            check_flit(got, make_flit(TAIL, sum));
        end
    endtask

    task automatic read_words(input int fd, input logic [31:0] hdr);
        logic [31:0] w;
        pkt_words.delete();
        for (int k = 0; k < int'(hdr[23:16]); k++) begin
            void'($fscanf(fd, "%h", w));
            pkt_words.push_back(w);
        end
    endtask

    task automatic finish_test(input string name);
        if (tx_q.size() != 0) begin
            $display("error at %0t: %0d unexpected tx flits", $time, tx_q.size());
            test_errs++;
            tx_q.delete();
        end
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests_run, name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    initial begin
        int fd;
        int c;
        int f[5];
        string cmd;
        string name;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [31:0] hdr;
        logic [3:0] strb;
        logic exp_err;
        logic err;
        logic done;
        logic good;
        rx_entry_t exp_entry;
        n_rst = 1'b0;
        apb_req = '0;
        rx_flit = '0;
        node_id = NODE_ID;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        aborted = 1'b0;
        repeat (16) @(posedge clk);
        n_rst <= 1'b1;
        fd = $fopen("sim/endpoint_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && $fscanf(fd, "%s", cmd) == 1) begin
            if (cmd.getc(0) == "#") begin
                do c = $fgetc(fd); while (c != 10 && c != -1);
            end else if (cmd == "W") begin
                void'($fscanf(fd, "%h %h %h %h", addr, data, strb, exp_err));
                apb_access(1'b1, addr, data, strb, rdata, err, done);
                if (done) check_word("pslverr", 32'(err), 32'(exp_err));
            end else if (cmd == "R") begin
                void'($fscanf(fd, "%h %h %h", addr, data, exp_err));
                apb_access(1'b0, addr, '0, '0, rdata, err, done);
                if (done) begin
                    check_word("read data", rdata, data);
                    check_word("pslverr", 32'(err), 32'(exp_err));
                end
            end else if (cmd == "P") begin
                void'($fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]));
                exp_entry.src = 4'(f[0]);
                exp_entry.len = 8'(f[1]);
                exp_entry.start = 7'(f[2]);
                exp_entry.meta = 7'(f[3]);
                exp_entry.crc_err = 1'(f[4]);
                apb_access(1'b0, FIFO_POP_ADDR, '0, '0, rdata, err, done);
                if (done) begin
                    check_entry(rx_entry_t'(rdata[$bits(rx_entry_t)-1:0]), exp_entry);
                    check_word("pslverr", 32'(err), 32'd0);
                end
            end else if (cmd == "I") begin
                void'($fscanf(fd, "%h %h", hdr, good));
                read_words(fd, hdr);
                inject_packet(hdr, good);
            end else if (cmd == "X") begin
                void'($fscanf(fd, "%h", hdr));
                read_words(fd, hdr);
                expect_packet(hdr);
            end else if (cmd == "E") begin
                void'($fscanf(fd, "%s", name));
                finish_test(name);
            end else begin
                $display("unknown stimulus command %s", cmd);
                aborted = 1'b1;
            end
        end
        if (fd != 0) $fclose(fd);
        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (!aborted && tests_failed == 0 && test_errs == 0 && tests_run > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim/endpoint_stimulus.txt
# W addr data strb err | R addr data err | P src len start meta err (pop and compare)
# I header good payload... | X stored_header payload... | E test_name   (all values hex)
W 0004 000001A7 F 0
R 0004 000001A4 0
W 000C 00000052 F 0
R 000C 00000050 0
W 2100 11223344 F 0
W 2100 AABBCCDD 5 0
R 2100 11BB33DD 0
W 21FC CAFEF00D F 0
R 21FC CAFEF00D 0
E regs_and_cache
W 0000 00000000 F 0
W 0004 00000040 F 0
W 0008 00000080 F 0
W 2000 2F020200 F 0
W 2004 10000001 F 0
W 2008 10000002 F 0
W 2040 30012000 F 0
W 2044 11111111 F 0
W 2080 4A037E00 F 0
W 2084 12345678 F 0
W 2088 9ABCDEF0 F 0
W 208C 0F0F0F0F F 0
W 1004 00000002 F 0
W 1004 00000001 F 0
W 1004 00000000 F 0
X 4A037E00 12345678 9ABCDEF0 0F0F0F0F
X 2F020200 10000001 10000002
X 30012000 11111111
E send_packets
I 57034400 1 A0000001 A0000002 A0000003
I 59020A00 1 B0000001 B0000002
P 7 03 00 22 0
P 9 02 03 05 0
R 3000 A0000001 0
R 3008 A0000003 0
R 300C B0000001 0
R 3010 B0000002 0
E receive_packets
I 5302FE00 0 C0000001 C0000002
P 3 02 05 7F 1
R 3014 C0000001 0
R 3018 C0000002 0
E bad_checksum
W 1004 00000004 F 1
W 3000 12345678 F 1
R 3000 A0000001 0
R 5000 00000000 1
W 3400 00000000 F 1
W 3404 00000000 F 1
R 3400 00000000 0
R 3404 00000000 0
E access_errors
I 51010200 1 D0000001
I 52010400 1 D0000002
I 53010600 1 D0000003
I 54010800 1 D0000004
I 55010A00 1 D0000005
I 56010C00 1 D0000006
I 57010E00 1 D0000007
I 58011000 1 D0000008
I 59011200 1 D0000009
R 3404 00000108 0
P 1 01 07 01 0
P 2 01 08 02 0
P 3 01 09 03 0
P 4 01 0A 04 0
P 5 01 0B 05 0
P 6 01 0C 06 0
P 7 01 0D 07 0
P 8 01 0E 08 0
R 3404 00000100 0
E fifo_overflow

// File: endpoint.f
logic/chiplet_pkg.sv
logic/endpoint_map_pkg.sv
logic/word_cache.sv
logic/tx_engine.sv
logic/rx_engine.sv
logic/req_fifo.sv
logic/endpoint.sv
sim/endpoint_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the endpoint testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim_run.log

verilator --binary --timing --assert --top-module endpoint_tb -f endpoint.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vendpoint_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1
